//--- source/motion_pkg.sv
// Shared widths, opcodes and the command word layout; modules refer to them by package scope
package motion_pkg;

  // SPI framing
  localparam int word_bits = 64;

  // Header opcodes, low byte of a header word
  localparam logic [7:0] op_move   = 8'd1; // Next word is a move payload
  localparam logic [7:0] op_status = 8'd2; // Next sent word carries status
  localparam logic [7:0] op_enable = 8'd3; // Driver enable from bit 8

  // Motion fields
  localparam int steps_bits    = 16;
  localparam int period_bits   = 16;
  localparam int position_bits = 32;
  localparam int move_bits     = 1 + steps_bits + period_bits; // dir, steps, period

  // Move buffer
  localparam int buffer_depth = 4;
  localparam int count_bits   = 3;

  // Internal reset hold after resetn rises
  localparam int reset_stretch = 8;

  // One received word, read as a header or as a move payload
  typedef union packed {
    struct packed {
      logic [47:0] reserved;
      logic [7:0]  arg;
      logic [7:0]  opcode;
    } header;
    struct packed {
      logic [30:0]            reserved;
      logic                   dir;
      logic [steps_bits-1:0]  steps;
      logic [period_bits-1:0] period;
    } move;
  } cmd_word_u;

endpackage

//--- source/spi_word.sv
// SPI mode-0 target on CLK; assembles 64-bit words LSB first and returns the send word on CIPO
`timescale 1ns/1ns

module spi_word (
  input  logic                               CLK,
  input  logic                               resetn,
  input  logic                               SCK,
  input  logic                               CS,
  input  logic                               COPI,
  input  logic [motion_pkg::word_bits-1:0]   word_send_data,
  output logic                               CIPO,
  output logic                               word_received,
  output logic [motion_pkg::word_bits-1:0]   word_data_received
);

  logic [2:0] sck_q;  // Two sync stages plus edge history
  logic [2:0] cs_q;
  logic [1:0] copi_q;
  logic [$clog2(motion_pkg::word_bits)-1:0] bit_cnt;
  logic [motion_pkg::word_bits-1:0] rx_shift;
  logic [motion_pkg::word_bits-1:0] tx_shift;
  logic sck_rise;
  logic sck_fall;
  logic cs_active;
  logic cs_fall;
  logic tx_load;
  logic tx_next;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= '0;
      cs_q   <= '1;  // Deselected
      copi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], SCK};
      cs_q   <= {cs_q[1:0], CS};
      copi_q <= {copi_q[0], COPI};
    end
  end

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign cs_active = ~cs_q[1];
  assign cs_fall   = ~cs_q[1] & cs_q[2];

  // Bit counter wraps to zero at each word boundary
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt       <= '0;
      word_received <= 1'b0;
    end else begin
      word_received <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;  // Partial word dropped
      end else if (sck_rise) begin
        bit_cnt       <= bit_cnt + 1'b1;
        word_received <= (bit_cnt == '1);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise)
      rx_shift <= {copi_q[1], rx_shift[motion_pkg::word_bits-1:1]};
  end

  assign word_data_received = rx_shift;  // Stable until the next rising edge

  // New send word on select and on the first falling edge after a boundary
  assign tx_load = cs_fall || (cs_active && sck_fall && bit_cnt == '0);
  assign tx_next = cs_active && sck_fall;

  always_ff @(posedge CLK) begin
    if (tx_load)
      tx_shift <= word_send_data;
    else if (tx_next)
      tx_shift <= tx_shift >> 1;
  end

  always_ff @(posedge CLK) begin
    if (!resetn)
      CIPO <= 1'b0;
    else if (tx_load)
      CIPO <= word_send_data[0];
    else if (tx_next)
      CIPO <= tx_shift[1];
    else if (!cs_active)
      CIPO <= 1'b0;
  end

  // Each word completes over many SCK levels, so strobes never merge
  a_word_pulse: assert property (@(posedge CLK) disable iff (!resetn)
    word_received |=> !word_received);

endmodule

//--- source/command_parser.sv
// Decodes SPI words into moves, enable and status replies; feeds the move buffer
`timescale 1ns/1ns

module command_parser (
  input  logic                                        CLK,
  input  logic                                        resetn,
  input  logic                                        word_received,
  input  logic [motion_pkg::word_bits-1:0]            word_data_received,
  input  logic signed [motion_pkg::position_bits-1:0] position,
  input  logic [motion_pkg::count_bits-1:0]           count,
  input  logic                                        busy,
  output logic [motion_pkg::word_bits-1:0]            word_send_data,
  output logic                                        push,
  output logic [motion_pkg::move_bits-1:0]            push_data,
  output logic                                        enable
);

  motion_pkg::cmd_word_u cmd;
  logic armed;  // Next word is a move payload

  assign cmd = word_data_received;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      armed          <= 1'b0;
      push           <= 1'b0;
      enable         <= 1'b0;
      word_send_data <= '0;
    end else begin
      push <= 1'b0;
      if (word_received) begin
        if (armed) begin
          armed <= 1'b0;
          if (cmd.move.steps != '0)
            push <= 1'b1;  // Zero-step payloads are dropped
        end else begin
          case (cmd.header.opcode)
            motion_pkg::op_move: begin
              armed <= 1'b1;
            end
            motion_pkg::op_status: begin
              // Position low, then count and busy above it
              word_send_data <= {
                {(motion_pkg::word_bits - motion_pkg::position_bits
                  - motion_pkg::count_bits - 1){1'b0}},
                busy,
                count,
                position
              };
            end
            motion_pkg::op_enable: begin
              enable <= cmd.header.arg[0];
            end
            default: begin
              // Unknown opcodes ignored
            end
          endcase
        end
      end
    end
  end

  // Move entry layout matches the buffer and step generator
  always_ff @(posedge CLK) begin
    if (word_received && armed)
      push_data <= {cmd.move.dir, cmd.move.steps, cmd.move.period};
  end

  a_push_follows_word: assert property (@(posedge CLK) disable iff (!resetn)
    push |-> $past(word_received));

endmodule

//--- source/move_buffer.sv
// Small circular FIFO of queued moves between the parser and the step generator
`timescale 1ns/1ns

module move_buffer (
  input  logic                                CLK,
  input  logic                                resetn,
  input  logic                                flush,
  input  logic                                push,
  input  logic [motion_pkg::move_bits-1:0]    push_data,
  input  logic                                pop,
  output logic [motion_pkg::move_bits-1:0]    head_data,
  output logic                                empty,
  output logic [motion_pkg::count_bits-1:0]   count,
  output logic                                buffer_dtr
);

  logic [motion_pkg::move_bits-1:0] mem [motion_pkg::buffer_depth];
  logic [$clog2(motion_pkg::buffer_depth)-1:0] wr_ptr;
  logic [$clog2(motion_pkg::buffer_depth)-1:0] rd_ptr;
  logic [motion_pkg::count_bits-1:0] next_count;
  logic do_push;
  logic do_pop;

  assign do_push = push && (count != motion_pkg::count_bits'(motion_pkg::buffer_depth));
  assign do_pop  = pop && !empty;

  always_comb begin
    next_count = count;
    if (do_push && !do_pop)
      next_count = count + 1'b1;
    else if (do_pop && !do_push)
      next_count = count - 1'b1;
  end

  always_ff @(posedge CLK) begin
    if (!resetn || flush) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      buffer_dtr <= 1'b1;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == ($bits(wr_ptr))'(motion_pkg::buffer_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ($bits(rd_ptr))'(motion_pkg::buffer_depth - 1)) ? '0 : rd_ptr + 1'b1;
      count      <= next_count;
      buffer_dtr <= (next_count != motion_pkg::count_bits'(motion_pkg::buffer_depth));
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  assign head_data = mem[rd_ptr];
  assign empty     = (count == '0);

  a_count_range: assert property (@(posedge CLK) disable iff (!resetn)
    count <= motion_pkg::count_bits'(motion_pkg::buffer_depth));
  a_no_pop_empty: assert property (@(posedge CLK) disable iff (!resetn)
    !(pop && empty));

endmodule

//--- source/step_generator.sv
// Pops buffered moves and times STEP pulses, keeps DIR and the signed position
`timescale 1ns/1ns

module step_generator (
  input  logic                                        CLK,
  input  logic                                        resetn,
  input  logic                                        halt,
  input  logic                                        empty,
  input  logic [motion_pkg::move_bits-1:0]            head_data,
  output logic                                        pop,
  output logic                                        step,
  output logic                                        dir,
  output logic signed [motion_pkg::position_bits-1:0] position,
  output logic                                        busy,
  output logic                                        move_done
);

  logic running;  // Idle or run
  logic [motion_pkg::period_bits-1:0] head_period;
  logic [motion_pkg::period_bits-1:0] start_period;
  logic [motion_pkg::period_bits-1:0] period_q;
  logic [motion_pkg::period_bits-1:0] tick_cnt;
  logic [motion_pkg::steps_bits-1:0]  steps_left;
  logic fire;

  assign head_period  = head_data[motion_pkg::period_bits-1:0];
  assign start_period = (head_period < 2) ? motion_pkg::period_bits'(2) : head_period;

  assign pop  = !running && !empty && !halt;
  assign fire = running && !halt && (tick_cnt == 1) && (steps_left != '0);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      running    <= 1'b0;
      tick_cnt   <= '0;
      steps_left <= '0;
      step       <= 1'b0;
      dir        <= 1'b0;
    end else begin
      step <= fire;
      if (halt) begin
        running    <= 1'b0;  // Move abandoned
        steps_left <= '0;
      end else if (pop) begin
        running    <= 1'b1;
        dir        <= head_data[motion_pkg::move_bits-1];
        steps_left <= head_data[motion_pkg::period_bits +: motion_pkg::steps_bits];
        tick_cnt   <= start_period - 1'b1;  // First pulse lands period cycles after pop
      end else if (running) begin
        if (fire) begin
          tick_cnt   <= period_q;
          steps_left <= steps_left - 1'b1;
        end else begin
          tick_cnt <= tick_cnt - 1'b1;
        end
        // Last pulse out, idle next cycle
        if (step && steps_left == '0)
          running <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (pop)
      period_q <= start_period;
  end

  always_ff @(posedge CLK) begin
    if (!resetn)
      position <= '0;
    else if (step)
      position <= dir ? position + 1'b1 : position - 1'b1;
  end

  assign busy      = running;
  assign move_done = !running && empty;

  a_step_width: assert property (@(posedge CLK) disable iff (!resetn)
    step |=> !step);

endmodule

//--- source/motion_core.sv
// Single-axis stepper motion core top level; the host drives it over SPI
`timescale 1ns/1ns

module motion_core (
  input  logic CLK,
  input  logic resetn,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  output logic STEP,
  output logic DIR,
  output logic ENABLE,
  output logic BUFFER_DTR,
  output logic MOVE_DONE,
  input  logic HALT
);

  logic [$clog2(motion_pkg::reset_stretch + 1)-1:0] stretch_cnt;
  logic core_resetn;
  logic [motion_pkg::word_bits-1:0] word_send_data;
  logic [motion_pkg::word_bits-1:0] word_data_received;
  logic word_received;
  logic signed [motion_pkg::position_bits-1:0] position;
  logic [motion_pkg::count_bits-1:0] count;
  logic busy;
  logic push;
  logic [motion_pkg::move_bits-1:0] push_data;
  logic [motion_pkg::move_bits-1:0] head_data;
  logic pop;
  logic empty;

  // Hold internal reset a few cycles past resetn
  always_ff @(posedge CLK) begin
    if (!resetn)
      stretch_cnt <= '0;
    else if (!core_resetn)
      stretch_cnt <= stretch_cnt + 1'b1;
  end

  assign core_resetn = (stretch_cnt == motion_pkg::reset_stretch);

  spi_word i_spi_word (
    .CLK(CLK), .resetn(core_resetn), .SCK(SCK), .CS(CS), .COPI(COPI),
    .word_send_data(word_send_data), .CIPO(CIPO),
    .word_received(word_received), .word_data_received(word_data_received));

  command_parser i_command_parser (
    .CLK(CLK), .resetn(core_resetn), .word_received(word_received),
    .word_data_received(word_data_received), .position(position), .count(count),
    .busy(busy), .word_send_data(word_send_data), .push(push), .push_data(push_data),
    .enable(ENABLE));

  move_buffer i_move_buffer (
    .CLK(CLK), .resetn(core_resetn), .flush(HALT), .push(push), .push_data(push_data),
    .pop(pop), .head_data(head_data), .empty(empty), .count(count),
    .buffer_dtr(BUFFER_DTR));

  step_generator i_step_generator (
    .CLK(CLK), .resetn(core_resetn), .halt(HALT), .empty(empty), .head_data(head_data),
    .pop(pop), .step(STEP), .dir(DIR), .position(position), .busy(busy),
    .move_done(MOVE_DONE));

endmodule

//--- verif/tb_clock.sv
// Free-running clock source for the motion core testbench, 4 ns period
`timescale 1ns/1ns

module tb_clock (
  output logic CLK
);

  initial CLK = 1'b0;

  always #2 CLK = ~CLK;  // Half period

endmodule

//--- verif/tb_motion_core.sv
// Testbench top for the motion core; sends SPI words, drives HALT and checks steps and status
`timescale 1ns/1ns

module tb_motion_core;

  logic CLK;
  logic resetn;
  logic SCK;
  logic CS;
  logic COPI;
  logic HALT;
  logic CIPO;
  logic STEP;
  logic DIR;
  logic ENABLE;
  logic BUFFER_DTR;
  logic MOVE_DONE;
  int mismatches = 0;
  int failures = 0;
  logic checking = 1'b0;
  logic spi_busy = 1'b0;    // High while a word is on the wire
  logic exp_enable = 1'b0;
  logic [31:0] lfsr = 32'h83cc_ac4d;
  // Expected moves in queuing order
  logic exp_dir [64];
  int exp_steps [64];
  int exp_period [64];
  int wr_count = 0;
  int rd_count = 0;
  int model_pos = 0;
  // Move currently executed by the DUT
  logic move_active = 1'b0;
  logic halted = 1'b0;
  logic cur_dir = 1'b0;
  int cur_steps = 0;
  int cur_period = 0;
  int pulses = 0;
  int gap = 0;              // Cycles since pop or last STEP
  int pulse_pos = 0;
  logic [63:0] rx;
  int i;
  int d;
  int s;
  int p;

  tb_clock i_tb_clock (.CLK(CLK));

  motion_core i_motion_core (
    .CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .STEP(STEP), .DIR(DIR), .ENABLE(ENABLE), .BUFFER_DTR(BUFFER_DTR),
    .MOVE_DONE(MOVE_DONE), .HALT(HALT));

  task automatic mismatch(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    mismatches++;
    $display("MISMATCH at %0t ns: %s expected 0x%0h actual 0x%0h", $time, name, exp_v, act_v);
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic check(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    assert (act_v == exp_v) else mismatch(name, exp_v, act_v);
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // One CS frame with 4 CLK cycles per SCK level and CIPO taken before each rising edge
  task automatic send_word(input logic [63:0] tx, output logic [63:0] rx_w);
    spi_busy = 1'b1;
    CS = 1'b0;
    for (int b = 0; b < 64; b++) begin
      COPI = tx[b];
      tick(4);
      rx_w[b] = CIPO;
      SCK = 1'b1;
      tick(4);
      SCK = 1'b0;
    end
    tick(4);
    CS = 1'b1;
    COPI = 1'b0;
    tick(6);
    spi_busy = 1'b0;
  endtask

  task automatic send_move(input logic dir, input int steps, input int period,
                           input logic accepted);
    logic [63:0] unused;
    send_word({48'h0, 8'h00, motion_pkg::op_move}, unused);
    if (steps != 0 && accepted) begin  // Zero-step and overflow payloads never run
      exp_dir[wr_count % 64] = dir;
      exp_steps[wr_count % 64] = steps;
      exp_period[wr_count % 64] = (period < 2) ? 2 : period;
      wr_count = wr_count + 1;
      model_pos = model_pos + (dir ? steps : -steps);
    end
    send_word({31'h0, dir, steps[15:0], period[15:0]}, unused);
  endtask

  task automatic read_status(output logic [63:0] w);
    logic [63:0] unused;
    send_word({48'h0, 8'h00, motion_pkg::op_status}, unused);
    send_word(64'h0, w);  // Opcode 0 is ignored
  endtask

  task automatic check_status();
    logic [63:0] w;
    read_status(w);
    check("status position", model_pos[31:0], w[31:0]);
    check("status count", 0, w[34:32]);
    check("status busy", 0, w[35]);
    check("status upper bits", 0, w[63:36]);
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (!MOVE_DONE && n < limit) begin
      tick(1);
      n++;
    end
    if (!MOVE_DONE)
      report_failure($sformatf("MOVE_DONE did not rise within %0d cycles", limit));
  endtask

  // Follows pops and STEP pulses against the expected moves
  always @(posedge CLK) begin
    gap <= gap + 1;
    if (i_motion_core.pop) begin
      move_active <= 1'b1;
      halted      <= 1'b0;
      cur_dir     <= exp_dir[rd_count % 64];
      cur_steps   <= exp_steps[rd_count % 64];
      cur_period  <= exp_period[rd_count % 64];
      rd_count    <= rd_count + 1;
      pulses      <= 0;
      gap         <= 1;
    end
    if (STEP) begin
      pulses    <= pulses + 1;
      pulse_pos <= cur_dir ? pulse_pos + 1 : pulse_pos - 1;
      gap       <= 1;
    end
    if (HALT) begin
      halted   <= 1'b1;
      rd_count <= wr_count;  // Buffer flushed
    end
  end

  a_pop_expected: assert property (@(posedge CLK) disable iff (!checking)
    i_motion_core.pop |-> rd_count != wr_count)
    else report_failure("DUT started a move that was never queued");
  a_dir: assert property (@(posedge CLK) disable iff (!checking)
    move_active |-> DIR == cur_dir)
    else mismatch("DIR", $sampled(cur_dir), $sampled(DIR));
  a_step_in_move: assert property (@(posedge CLK) disable iff (!checking)
    STEP |-> move_active && !halted && pulses < cur_steps)
    else report_failure("STEP pulse outside a running move or beyond its step count");
  a_step_count: assert property (@(posedge CLK) disable iff (!checking)
    (move_active && !halted && (i_motion_core.pop || MOVE_DONE)) |-> pulses == cur_steps)
    else mismatch("STEP count", $sampled(cur_steps), $sampled(pulses));
  a_spacing: assert property (@(posedge CLK) disable iff (!checking)
    STEP |-> gap == cur_period)
    else mismatch("STEP spacing", $sampled(cur_period), $sampled(gap));
  a_halt_stop: assert property (@(posedge CLK) disable iff (!checking)
    HALT |=> !STEP && MOVE_DONE)
    else report_failure("STEP still pulsing or MOVE_DONE low after HALT");
  a_enable: assert property (@(posedge CLK) disable iff (!checking)
    !spi_busy |-> ENABLE == exp_enable)
    else mismatch("ENABLE", $sampled(exp_enable), $sampled(ENABLE));

  initial begin
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    HALT = 1'b0;
    tick(16);
    resetn = 1'b1;
    tick(motion_pkg::reset_stretch + 4);
    checking = 1'b1;
    check("STEP", 0, STEP);
    check("DIR", 0, DIR);
    check("ENABLE", 0, ENABLE);
    check("CIPO", 0, CIPO);
    check("BUFFER_DTR", 1, BUFFER_DTR);
    check("MOVE_DONE", 1, MOVE_DONE);
    exp_enable = 1'b1;
    send_word({48'h0, 8'h01, motion_pkg::op_enable}, rx);
    for (i = 0; i < 6; i++) begin
      d = rand_bits(1);
      s = 1 + rand_bits(5) % 20;
      p = 2 + rand_bits(3);
      send_move(d[0], s, p, 1'b1);
      wait_done(2000);
      check_status();
    end
    send_move(1'b0, 5, 0, 1'b1);  // Clamped to 2 cycles
    wait_done(2000);
    check_status();
    // Long move keeps the generator busy while four more fill the buffer
    send_move(1'b1, 500, 16, 1'b1);
    for (i = 0; i < 5; i++) begin
      send_move(i[0], 100, 10, i < 4);
      if (i == 2)
        check("BUFFER_DTR", 1, BUFFER_DTR);
      if (i == 3)
        check("BUFFER_DTR", 0, BUFFER_DTR);
    end
    wait_done(20000);
    check_status();
    send_move(1'b0, 200, 12, 1'b1);
    send_move(1'b1, 50, 4, 1'b1);
    tick(100);
    HALT = 1'b1;
    tick(2);
    HALT = 1'b0;
    wait_done(100);
    tick(2);
    assert (pulses > 0 && pulses < 200) else report_failure("HALT did not land inside the move");
    model_pos = pulse_pos;  // Only counted pulses moved the axis
    check_status();
    send_word({48'h0, 8'h00, 8'h5a}, rx);
    send_move(1'b1, 0, 5, 1'b1);
    tick(50);
    check_status();
    exp_enable = 1'b0;
    send_word({48'h0, 8'h00, motion_pkg::op_enable}, rx);
    check_status();
    $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- tb.f
source/motion_pkg.sv
source/spi_word.sv
source/command_parser.sv
source/move_buffer.sv
source/step_generator.sv
source/motion_core.sv
verif/tb_clock.sv
verif/tb_motion_core.sv
